// ==== hw/fetch_pkg.sv ====
// fetch front end shared definitions
// address, block and line types plus fixed fetch geometry

package fetch_pkg;

	localparam int PADDR_W = 32;                 // physical address width
	localparam int BLOCK_W = 128;                // one fetch block, four words
	localparam int BLOCKS_PER_LINE = 4;          // 64-byte line
	localparam int WORD_SEL_W = $clog2(BLOCKS_PER_LINE);
	localparam int FETCH_W = PADDR_W - 4;        // bits above the 16-byte offset
	localparam int LINE_W = PADDR_W - 6;         // bits above the 64-byte offset
	localparam int ROM_ENTRIES = 32;
	localparam int ROM_IDX_W = $clog2(ROM_ENTRIES);

	// top bit selects the boot ROM
	typedef logic [FETCH_W-1:0] fetch_addr_t;

	typedef logic [LINE_W-1:0] line_addr_t;

	typedef logic [BLOCK_W-1:0] block_t;

	// element 0 is the lowest addressed block
	typedef block_t [BLOCKS_PER_LINE-1:0] line_t;

endpackage

// ==== hw/boot_rom.sv ====
// boot ROM
// small read-only table of fetch blocks, read combinationally,
// with contents taken from the boot image at elaboration

`timescale 1ns/1ns

module boot_rom
	import fetch_pkg::*;
(
	input  logic [ROM_IDX_W-1:0] i_index,
	output block_t               o_block
);

	block_t rom [ROM_ENTRIES];

	initial begin
		$readmemh("hw/boot_rom.hex", rom);   // one block per line
	end

	assign o_block = rom[i_index];

endmodule

// ==== hw/fetch_lane.sv ====
// per-hart fetch lane
// splits boot ROM from cached space on the top address bit, flags
// a usable block in the same cycle and registers ok and data
// for the hart unless it is stalled

`timescale 1ns/1ns

module fetch_lane
	import fetch_pkg::*;
(
	input  logic        clk,
	input  logic        reset,
	input  fetch_addr_t i_pc,
	input  logic        i_stall,
	input  logic        i_hit,           // icache lookup result
	input  block_t      i_cache_block,
	output line_addr_t  o_line_addr,
	output logic        o_need_fill,
	output logic        o_ok,
	output logic        o_okr,
	output block_t      o_data
);

	logic is_rom;
	block_t rom_block;
	block_t sel_block;

	assign is_rom = i_pc[FETCH_W-1];                      // top physical bit
	assign o_line_addr = i_pc[FETCH_W-1:WORD_SEL_W];

	boot_rom boot_rom_inst (
		.i_index(i_pc[ROM_IDX_W-1:0]),
		.o_block(rom_block)
	);

	// ROM is always ready, cache only on a hit
	assign o_ok = is_rom | i_hit;

	// the tracker decides whether the line is already on its way
	assign o_need_fill = !is_rom && !i_hit;

	assign sel_block = is_rom ? rom_block : i_cache_block;

	always_ff @(posedge clk) begin
		if (reset) begin
			o_okr <= 1'b0;
		end else if (!i_stall) begin
			o_okr <= o_ok;
		end
	end

	always_ff @(posedge clk) begin
		if (!i_stall) begin
			o_data <= sel_block;          // holds while stalled
		end
	end

endmodule

// ==== hw/icache_array.sv ====
// shared direct-mapped instruction cache store
// two combinational lookup ports, one per hart, and a single fill
// port that writes a whole line from memory

`timescale 1ns/1ns

module icache_array
	import fetch_pkg::*;
#(
	parameter int CACHE_LINES = 64
) (
	input  logic                  clk,
	input  logic                  reset,
	input  line_addr_t            i_rd_line_0,
	input  line_addr_t            i_rd_line_1,
	input  logic [WORD_SEL_W-1:0] i_rd_word_0,
	input  logic [WORD_SEL_W-1:0] i_rd_word_1,
	input  logic                  i_fill,
	input  line_addr_t            i_fill_line,
	input  line_t                 i_fill_data,
	output logic                  o_hit_0,
	output logic                  o_hit_1,
	output block_t                o_block_0,
	output block_t                o_block_1
);

	localparam int IDX_W = $clog2(CACHE_LINES);
	localparam int TAG_W = LINE_W - IDX_W;

	line_t data_mem [CACHE_LINES];
	logic [TAG_W-1:0] tag_mem [CACHE_LINES];
	logic [CACHE_LINES-1:0] valid;

	line_addr_t rd_line [2];
	logic [WORD_SEL_W-1:0] rd_word [2];
	logic [1:0] rd_hit;
	block_t rd_block [2];
	logic [IDX_W-1:0] fill_idx;

	assign rd_line[0] = i_rd_line_0;
	assign rd_line[1] = i_rd_line_1;
	assign rd_word[0] = i_rd_word_0;
	assign rd_word[1] = i_rd_word_1;

	for (genvar p = 0; p < 2; p++) begin : g_rd
		logic [IDX_W-1:0] idx;

		assign idx = rd_line[p][IDX_W-1:0];
		assign rd_hit[p] = valid[idx] && (tag_mem[idx] == rd_line[p][LINE_W-1:IDX_W]);
		assign rd_block[p] = data_mem[idx][rd_word[p]];   // pick one of four blocks
	end

	assign o_hit_0 = rd_hit[0];
	assign o_hit_1 = rd_hit[1];
	assign o_block_0 = rd_block[0];
	assign o_block_1 = rd_block[1];

	assign fill_idx = i_fill_line[IDX_W-1:0];

	always_ff @(posedge clk) begin
		if (reset) begin
			valid <= '0;                  // cache starts empty
		end else if (i_fill) begin
			valid[fill_idx] <= 1'b1;
		end
	end

	// a fill simply replaces whatever line sat at that index
	always_ff @(posedge clk) begin
		if (i_fill) begin
			data_mem[fill_idx] <= i_fill_data;
			tag_mem[fill_idx] <= i_fill_line[LINE_W-1:IDX_W];
		end
	end

endmodule

// ==== hw/miss_tracker.sv ====
// outstanding line fill tracker
// allocates one slot per cycle for a hart that missed, alternating
// between harts when both need a new line, sends each slot's line
// read once and turns the tagged return into a cache fill

`timescale 1ns/1ns

module miss_tracker
	import fetch_pkg::*;
#(
	parameter int NUM_SLOTS = 8,                 // power of two, tag is the slot number
	localparam int TAG_W = $clog2(NUM_SLOTS)
) (
	input  logic             clk,
	input  logic             reset,
	input  logic             i_need_0,
	input  logic             i_need_1,
	input  line_addr_t       i_line_0,
	input  line_addr_t       i_line_1,
	input  logic             i_mem_resp,
	input  logic [TAG_W-1:0] i_mem_tag,
	input  line_t            i_mem_data,
	output logic             o_mem_req,
	output logic [TAG_W-1:0] o_mem_tag,
	output line_addr_t       o_mem_addr,
	output logic             o_fill,
	output line_addr_t       o_fill_line,
	output line_t            o_fill_data
);

	line_addr_t slot_addr [NUM_SLOTS];
	logic [NUM_SLOTS-1:0] busy;
	logic [NUM_SLOTS-1:0] sent;              // read already issued
	logic [TAG_W-1:0] issue_ptr;
	logic sched;                             // which hart wins a tie

	logic [NUM_SLOTS-1:0] loading_0;
	logic [NUM_SLOTS-1:0] loading_1;
	logic same_line;
	logic want_0;
	logic want_1;
	logic both;
	logic any_free;
	logic [TAG_W-1:0] free_slot;
	logic alloc;
	logic alloc_hart;
	line_addr_t alloc_line;
	logic issue;
	logic [TAG_W-1:0] issue_slot;

	// line already loading
	always_comb begin
		for (int n = 0; n < NUM_SLOTS; n++) begin
			loading_0[n] = busy[n] && (slot_addr[n] == i_line_0);
			loading_1[n] = busy[n] && (slot_addr[n] == i_line_1);
		end
	end

	assign same_line = (i_line_0 == i_line_1);
	assign want_0 = i_need_0 && !(|loading_0);
	assign want_1 = i_need_1 && !(|loading_1) && !(want_0 && same_line);  // one slot per line
	assign both = want_0 && want_1;

	// lowest free slot
	always_comb begin
		any_free = 1'b0;
		free_slot = '0;
		for (int n = NUM_SLOTS - 1; n >= 0; n--) begin
			if (!busy[n]) begin
				any_free = 1'b1;
				free_slot = TAG_W'(n);
			end
		end
	end

	assign alloc = any_free && (want_0 || want_1);
	assign alloc_hart = both ? sched : want_1;
	assign alloc_line = alloc_hart ? i_line_1 : i_line_0;

	// first unsent slot at or after the pointer
	always_comb begin
		logic [TAG_W-1:0] cand;

		issue = 1'b0;
		issue_slot = issue_ptr;
		for (int k = NUM_SLOTS - 1; k >= 0; k--) begin
			cand = issue_ptr + TAG_W'(k);
			if (busy[cand] && !sent[cand]) begin
				issue = 1'b1;
				issue_slot = cand;
			end
		end
	end

	assign o_mem_req = issue;
	assign o_mem_tag = issue_slot;
	assign o_mem_addr = slot_addr[issue_slot];

	assign o_fill = i_mem_resp;
	assign o_fill_line = slot_addr[i_mem_tag];
	assign o_fill_data = i_mem_data;

	// issue, return and allocate always touch different slots
	always_ff @(posedge clk) begin
		if (reset) begin
			busy <= '0;
			sent <= '0;
			issue_ptr <= '0;
			sched <= 1'b0;
		end else begin
			if (issue) begin
				sent[issue_slot] <= 1'b1;
				issue_ptr <= issue_slot + 1'b1;    // wraps
			end
			if (i_mem_resp) begin
				busy[i_mem_tag] <= 1'b0;
			end
			if (alloc) begin
				busy[free_slot] <= 1'b1;
				sent[free_slot] <= 1'b0;
			end
			if (alloc && both) begin
				sched <= !sched;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (alloc) begin
			slot_addr[free_slot] <= alloc_line;
		end
	end

endmodule

// ==== hw/fetch_top.sv ====
// dual-hart instruction fetch front end
// two fetch lanes share one direct-mapped icache and a table of
// outstanding line fills feeding a tagged memory read port

`timescale 1ns/1ns

module fetch_top
	import fetch_pkg::*;
#(
	parameter int NUM_SLOTS = 8,
	parameter int CACHE_LINES = 64
) (
	input  logic                         clk,
	input  logic                         reset,

	input  fetch_addr_t                  i_pc_0,       // hart 0 fetch port
	input  logic                         i_stall_0,
	output logic                         o_ok_0,
	output logic                         o_okr_0,
	output block_t                       o_data_0,

	input  fetch_addr_t                  i_pc_1,       // hart 1 fetch port
	input  logic                         i_stall_1,
	output logic                         o_ok_1,
	output logic                         o_okr_1,
	output block_t                       o_data_1,

	input  logic                         i_mem_resp,   // line return
	input  logic [$clog2(NUM_SLOTS)-1:0] i_mem_tag,
	input  line_t                        i_mem_data,
	output logic                         o_mem_req,    // line read
	output logic [$clog2(NUM_SLOTS)-1:0] o_mem_tag,
	output line_addr_t                   o_mem_addr
);

	line_addr_t line_0;
	line_addr_t line_1;
	logic hit_0;
	logic hit_1;
	block_t cache_block_0;
	block_t cache_block_1;
	logic need_0;
	logic need_1;
	logic fill;
	line_addr_t fill_line;
	line_t fill_data;

	fetch_lane lane_0_inst (
		.clk(clk),
		.reset(reset),
		.i_pc(i_pc_0),
		.i_stall(i_stall_0),
		.i_hit(hit_0),
		.i_cache_block(cache_block_0),
		.o_line_addr(line_0),
		.o_need_fill(need_0),
		.o_ok(o_ok_0),
		.o_okr(o_okr_0),
		.o_data(o_data_0)
	);

	fetch_lane lane_1_inst (
		.clk(clk),
		.reset(reset),
		.i_pc(i_pc_1),
		.i_stall(i_stall_1),
		.i_hit(hit_1),
		.i_cache_block(cache_block_1),
		.o_line_addr(line_1),
		.o_need_fill(need_1),
		.o_ok(o_ok_1),
		.o_okr(o_okr_1),
		.o_data(o_data_1)
	);

	icache_array #(
		.CACHE_LINES(CACHE_LINES)
	) icache_array_inst (
		.clk(clk),
		.reset(reset),
		.i_rd_line_0(line_0),
		.i_rd_line_1(line_1),
		.i_rd_word_0(i_pc_0[WORD_SEL_W-1:0]),   // block within the line
		.i_rd_word_1(i_pc_1[WORD_SEL_W-1:0]),
		.i_fill(fill),
		.i_fill_line(fill_line),
		.i_fill_data(fill_data),
		.o_hit_0(hit_0),
		.o_hit_1(hit_1),
		.o_block_0(cache_block_0),
		.o_block_1(cache_block_1)
	);

	miss_tracker #(
		.NUM_SLOTS(NUM_SLOTS)
	) miss_tracker_inst (
		.clk(clk),
		.reset(reset),
		.i_need_0(need_0),
		.i_need_1(need_1),
		.i_line_0(line_0),
		.i_line_1(line_1),
		.i_mem_resp(i_mem_resp),
		.i_mem_tag(i_mem_tag),
		.i_mem_data(i_mem_data),
		.o_mem_req(o_mem_req),
		.o_mem_tag(o_mem_tag),
		.o_mem_addr(o_mem_addr),
		.o_fill(fill),
		.o_fill_line(fill_line),
		.o_fill_data(fill_data)
	);

endmodule

// ==== tests/tb_clock.sv ====
// testbench clock and reset source
// free-running clock with a synchronous reset held for a fixed
// number of cycles at the start of the run

`timescale 1ns/1ns

module tb_clock #(
	parameter int PERIOD = 20,
	parameter int RESET_CYCLES = 16
) (
	output logic o_clk,
	output logic o_reset
);

	initial begin
		o_clk = 1'b0;
		forever begin
			#(PERIOD / 2) o_clk = ~o_clk;
		end
	end

	initial begin
		o_reset = 1'b1;
		repeat (RESET_CYCLES) @(posedge o_clk);
		@(negedge o_clk);
		o_reset = 1'b0;               // released between rising edges
	end

endmodule

// ==== tests/tb_fetch.sv ====
// testbench for the dual-hart fetch front end
// random pcs and stalls from an LFSR, a delayed line memory and a
// cache model that predicts ok, registered blocks and fill traffic

`timescale 1ns/1ns

module tb_fetch
	import fetch_pkg::*;
();

	localparam int NUM_SLOTS = 8;
	localparam int TAG_W = $clog2(NUM_SLOTS);
	localparam int CACHE_LINES = 64;
	localparam int IDX_W = $clog2(CACHE_LINES);
	localparam int RESET_CYCLES = 16;
	localparam int NUM_CYCLES = 4000;
	localparam int CYCLE_LIMIT = RESET_CYCLES + NUM_CYCLES + 32;
	localparam int OK_LIMIT = 64;
	localparam line_addr_t POOL_BASE = 26'h0123400;
	localparam fetch_addr_t ROM_PC = 28'h800_0000;

	logic clk;
	logic reset;
	fetch_addr_t pc_0;
	fetch_addr_t pc_1;
	logic stall_0;
	logic stall_1;
	logic ok_0;
	logic ok_1;
	logic okr_0;
	logic okr_1;
	block_t data_0;
	block_t data_1;
	logic resp;
	logic [TAG_W-1:0] resp_tag;
	line_t resp_data;
	logic req;
	logic [TAG_W-1:0] req_tag;
	line_addr_t req_addr;

	logic [31:0] lfsr;
	block_t rom_image [ROM_ENTRIES];
	logic cache_valid [CACHE_LINES];          // model of the icache tags
	line_addr_t cache_line [CACHE_LINES];
	logic fill_pend;
	line_addr_t fill_pend_line;
	logic [TAG_W-1:0] pend_tag [$];           // outstanding reads
	line_addr_t pend_line [$];
	int pend_due [$];
	line_addr_t miss_lines [$];               // lines seen missing, read not yet sent
	fetch_addr_t pc_drv [2];
	logic stall_drv [2];
	logic exp_ok [2];
	logic exp_okr [2];
	fetch_addr_t pc_r [2];                    // pc at last unstalled edge
	block_t prev_data [2];
	logic seen_ok [2];
	int linger [2];
	int wait_cnt [2];
	int cycles = 0;

	tb_clock #(
		.PERIOD(20),
		.RESET_CYCLES(RESET_CYCLES)
	) clock_inst (
		.o_clk(clk),
		.o_reset(reset)
	);

	fetch_top #(
		.NUM_SLOTS(NUM_SLOTS),
		.CACHE_LINES(CACHE_LINES)
	) fetch_top_inst (
		.clk(clk),
		.reset(reset),
		.i_pc_0(pc_0),
		.i_stall_0(stall_0),
		.o_ok_0(ok_0),
		.o_okr_0(okr_0),
		.o_data_0(data_0),
		.i_pc_1(pc_1),
		.i_stall_1(stall_1),
		.o_ok_1(ok_1),
		.o_okr_1(okr_1),
		.o_data_1(data_1),
		.i_mem_resp(resp),
		.i_mem_tag(resp_tag),
		.i_mem_data(resp_data),
		.o_mem_req(req),
		.o_mem_tag(req_tag),
		.o_mem_addr(req_addr)
	);

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		if (s[0]) begin
			return (s >> 1) ^ 32'h8020_0003;
		end
		return s >> 1;
	endfunction

	// one LFSR step per bit taken
	task automatic draw(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_next(lfsr);
			v = {v[30:0], lfsr[0]};
		end
	endtask

	// memory rule, each word is the line address and its word index
	function automatic block_t mem_block(input line_addr_t addr, input logic [1:0] sel);
		block_t blk;
		for (int j = 0; j < 4; j++) begin
			blk[32*j +: 32] = {addr, 2'b00, sel, 2'(j)};
		end
		return blk;
	endfunction

	function automatic line_t mem_line(input line_addr_t addr);
		line_t l;
		for (int b = 0; b < 4; b++) begin
			l[b] = mem_block(addr, 2'(b));
		end
		return l;
	endfunction

	function automatic block_t model_block(input fetch_addr_t pc);
		if (pc[FETCH_W-1]) begin
			return rom_image[pc[ROM_IDX_W-1:0]];
		end
		return mem_block(pc[FETCH_W-1:WORD_SEL_W], pc[WORD_SEL_W-1:0]);
	endfunction

	function automatic logic expected_ok(input fetch_addr_t pc);
		line_addr_t addr;
		logic [IDX_W-1:0] idx;
		addr = pc[FETCH_W-1:WORD_SEL_W];
		idx = addr[IDX_W-1:0];
		return pc[FETCH_W-1] || (cache_valid[idx] && cache_line[idx] == addr);
	endfunction

	task automatic stop_run(input string msg);
		$display("%s", msg);
		$display("test failed");
		$fatal(1, "run stopped");
	endtask

	task automatic check_flag(input string name, input logic exp, input logic act);
		if (exp !== act) begin
			stop_run($sformatf("mismatch %s: expected %b, actual %b", name, exp, act));
		end
	endtask

	task automatic check_block(input string name, input block_t exp, input block_t act);
		if (exp !== act) begin
			stop_run($sformatf("mismatch %s: expected %h, actual %h", name, exp, act));
		end
	endtask

	task automatic apply_fill();
		logic [IDX_W-1:0] idx;
		idx = fill_pend_line[IDX_W-1:0];
		if (fill_pend) begin
			cache_valid[idx] = 1'b1;
			cache_line[idx] = fill_pend_line;
			fill_pend = 1'b0;
		end
	endtask

	task automatic check_registered(input int h, input logic okr, input block_t data);
		if (!stall_drv[h]) begin
			exp_okr[h] = exp_ok[h];
			pc_r[h] = pc_drv[h];
		end else begin
			check_block($sformatf("held data hart%0d", h), prev_data[h], data);
		end
		check_flag($sformatf("okr hart%0d", h), exp_okr[h], okr);
		if (exp_okr[h]) begin
			check_block($sformatf("data hart%0d", h), model_block(pc_r[h]), data);
		end
		prev_data[h] = data;
	endtask

	// a missed line stays listed until its read goes out
	task automatic note_miss(input line_addr_t addr);
		foreach (miss_lines[i]) begin
			if (miss_lines[i] == addr) begin
				return;
			end
		end
		miss_lines.push_back(addr);
	endtask

	task automatic record_request(input int now);
		logic [31:0] d;
		int due;
		int found;
		if (pend_tag.size() >= NUM_SLOTS) begin
			stop_run("more line reads outstanding than there are slots");
		end
		for (int i = 0; i < pend_tag.size(); i++) begin
			if (pend_tag[i] == req_tag) begin
				stop_run($sformatf("request reuses tag %0d while it is outstanding", req_tag));
			end
			if (pend_line[i] == req_addr) begin
				stop_run($sformatf("request for line %h while it is outstanding", req_addr));
			end
		end
		found = -1;
		for (int i = 0; i < miss_lines.size(); i++) begin
			if (miss_lines[i] == req_addr) begin
				found = i;
			end
		end
		if (found < 0) begin
			stop_run($sformatf("request for line %h that no hart missed on", req_addr));
		end else begin
			miss_lines.delete(found);
		end
		draw(4, d);
		if (d[3:0] == 4'd0) begin
			due = now + 1;
		end else begin
			due = now + int'(d[3:0]);             // 1 to 15 cycles
		end
		pend_tag.push_back(req_tag);
		pend_line.push_back(req_addr);
		pend_due.push_back(due);
	endtask

	// oldest due read goes back, one per cycle
	task automatic drive_response(input int now);
		int pick;
		pick = -1;
		for (int i = pend_tag.size() - 1; i >= 0; i--) begin
			if (pend_due[i] <= now) begin
				pick = i;
			end
		end
		resp = 1'b0;
		if (pick >= 0) begin
			resp = 1'b1;
			resp_tag = pend_tag[pick];
			resp_data = mem_line(pend_line[pick]);
			fill_pend = 1'b1;
			fill_pend_line = pend_line[pick];
			pend_tag.delete(pick);
			pend_line.delete(pick);
			pend_due.delete(pick);
		end
	endtask

	task automatic choose_pc(input int h);
		logic [31:0] r;
		logic [31:0] w;
		line_addr_t new_line;
		if (!seen_ok[h]) begin
			wait_cnt[h]++;
			if (wait_cnt[h] > OK_LIMIT) begin
				stop_run($sformatf("hart %0d pc %h got no ok within %0d cycles",
					h, pc_drv[h], OK_LIMIT));
			end
		end else if (linger[h] > 0) begin
			linger[h]--;
		end else begin
			draw(3, r);
			if (r[2:0] == 3'd0) begin
				draw(27, w);
				pc_drv[h] = {1'b1, w[26:0]};      // boot ROM
			end else begin
				draw(6, w);
				new_line = POOL_BASE | {19'd0, w[3], 3'b000, w[2:0]};
				pc_drv[h] = {new_line, w[5:4]};
			end
			seen_ok[h] = 1'b0;
			wait_cnt[h] = 0;
			draw(2, r);
			linger[h] = int'(r[1:0]);
		end
		draw(2, r);
		stall_drv[h] = (r[1:0] == 2'b00);
	endtask

	task automatic sample_ok(input int h, input logic act);
		exp_ok[h] = expected_ok(pc_drv[h]);
		if (pc_drv[h][FETCH_W-1]) begin
			check_flag($sformatf("rom ok hart%0d", h), 1'b1, act);
		end
		check_flag($sformatf("ok hart%0d", h), exp_ok[h], act);
		if (exp_ok[h]) begin
			seen_ok[h] = 1'b1;
		end else begin
			note_miss(pc_drv[h][FETCH_W-1:WORD_SEL_W]);
		end
	endtask

	always @(posedge clk) begin
		cycles++;
		if (cycles >= CYCLE_LIMIT) begin
			stop_run($sformatf("timeout after %0d cycles", cycles));
		end
	end

	initial begin
		pc_0 = ROM_PC;
		pc_1 = ROM_PC;
		stall_0 = 1'b0;
		stall_1 = 1'b0;
		resp = 1'b0;
		resp_tag = '0;
		resp_data = '0;
		lfsr = 32'hf6ea_5c69;
		$readmemh("hw/boot_rom.hex", rom_image);
		for (int i = 0; i < CACHE_LINES; i++) begin
			cache_valid[i] = 1'b0;
			cache_line[i] = '0;
		end
		fill_pend = 1'b0;
		fill_pend_line = '0;
		for (int h = 0; h < 2; h++) begin
			pc_drv[h] = ROM_PC;
			stall_drv[h] = 1'b0;
			exp_okr[h] = 1'b0;
			pc_r[h] = ROM_PC;
			prev_data[h] = '0;
			seen_ok[h] = 1'b1;
			linger[h] = 0;
			wait_cnt[h] = 0;
		end

		@(negedge reset);
		#1;
		check_flag("okr hart0 after reset", 1'b0, okr_0);
		check_flag("okr hart1 after reset", 1'b0, okr_1);
		check_flag("mem req after reset", 1'b0, req);
		sample_ok(0, ok_0);
		sample_ok(1, ok_1);

		for (int n = 0; n < NUM_CYCLES; n++) begin
			@(negedge clk);
			apply_fill();                         // line written at the last edge
			check_registered(0, okr_0, data_0);
			check_registered(1, okr_1, data_1);
			if (req) begin
				record_request(n);
			end
			drive_response(n);
			choose_pc(0);
			choose_pc(1);
			pc_0 = pc_drv[0];
			pc_1 = pc_drv[1];
			stall_0 = stall_drv[0];
			stall_1 = stall_drv[1];
			#1;
			sample_ok(0, ok_0);
			sample_ok(1, ok_1);
		end

		$display("test passed");
		$finish;
	end

endmodule

// ==== hw/boot_rom.hex ====
// boot ROM image, one 128-bit fetch block per line, entry 0 first
// each block holds four 32-bit words b000_<entry>_0<word>, word 3 leftmost
b0000003b0000002b0000001b0000000
b0000103b0000102b0000101b0000100
b0000203b0000202b0000201b0000200
b0000303b0000302b0000301b0000300
b0000403b0000402b0000401b0000400
b0000503b0000502b0000501b0000500
b0000603b0000602b0000601b0000600
b0000703b0000702b0000701b0000700
b0000803b0000802b0000801b0000800
b0000903b0000902b0000901b0000900
b0000a03b0000a02b0000a01b0000a00
b0000b03b0000b02b0000b01b0000b00
b0000c03b0000c02b0000c01b0000c00
b0000d03b0000d02b0000d01b0000d00
b0000e03b0000e02b0000e01b0000e00
b0000f03b0000f02b0000f01b0000f00
b0001003b0001002b0001001b0001000
b0001103b0001102b0001101b0001100
b0001203b0001202b0001201b0001200
b0001303b0001302b0001301b0001300
b0001403b0001402b0001401b0001400
b0001503b0001502b0001501b0001500
b0001603b0001602b0001601b0001600
b0001703b0001702b0001701b0001700
b0001803b0001802b0001801b0001800
b0001903b0001902b0001901b0001900
b0001a03b0001a02b0001a01b0001a00
b0001b03b0001b02b0001b01b0001b00
b0001c03b0001c02b0001c01b0001c00
b0001d03b0001d02b0001d01b0001d00
b0001e03b0001e02b0001e01b0001e00
b0001f03b0001f02b0001f01b0001f00

// ==== tb.f ====
hw/fetch_pkg.sv
hw/boot_rom.sv
hw/fetch_lane.sv
hw/icache_array.sv
hw/miss_tracker.sv
hw/fetch_top.sv
tests/tb_clock.sv
tests/tb_fetch.sv

// ==== Makefile ====
TOP := tb_fetch

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --top-module fetch_top hw/fetch_pkg.sv hw/boot_rom.sv \
		hw/fetch_lane.sv hw/icache_array.sv hw/miss_tracker.sv hw/fetch_top.sv

sim:
	verilator --binary --timing -Wno-fatal --top-module $(TOP) -f tb.f -Mdir obj_dir -o $(TOP)
	./obj_dir/$(TOP)

clean:
	rm -rf obj_dir
